//--- verilog/glb_defines.svh
// global buffer bank parameters
// shared widths for the bank datapath and the configuration port

`ifndef GLB_DEFINES_SVH
`define GLB_DEFINES_SVH

// byte address width of one bank
`define GLB_BANK_ADDR_WIDTH 12

// sram word width
`define GLB_BANK_DATA_WIDTH 64

// byte address bits inside one word
`define GLB_BANK_ADDR_BYTE_OFFSET 3

// configuration half-word width
`define GLB_CONFIG_DATA_WIDTH 32

`endif

//--- verilog/glb_bank_pkg.sv
// global buffer bank types
// host port and sram datapath types

`include "glb_defines.svh"

`default_nettype none

package glb_bank_pkg;

    // host byte address
    typedef logic [`GLB_BANK_ADDR_WIDTH-1:0] bank_addr_t;

    // full word, also used as a per-bit write mask
    typedef logic [`GLB_BANK_DATA_WIDTH-1:0] bank_data_t;

    // word address at the macro, byte offset dropped
    typedef logic [`GLB_BANK_ADDR_WIDTH-`GLB_BANK_ADDR_BYTE_OFFSET-1:0] mem_addr_t;

endpackage

`default_nettype wire

//--- verilog/glb_cfg_pkg.sv
// global buffer configuration types
// address and data of the half-word configuration port

`include "glb_defines.svh"

`default_nettype none

package glb_cfg_pkg;

    // configuration byte address, bit 2 picks the upper half
    typedef logic [`GLB_BANK_ADDR_WIDTH-1:0] cfg_addr_t;

    // configuration half-word
    typedef logic [`GLB_CONFIG_DATA_WIDTH-1:0] cfg_data_t;

endpackage

`default_nettype wire

//--- verilog/glb_bank_ctrl.sv
// bank control
// arbitrates host against configuration access to the sram
// configuration always wins and stalls the host for that cycle

`timescale 1ns/1ps

`include "glb_defines.svh"

`default_nettype none

module glb_bank_ctrl (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    host_ren,
    input  logic                    host_wen,
    input  glb_bank_pkg::bank_addr_t host_addr,
    input  glb_bank_pkg::bank_data_t host_data,
    input  glb_bank_pkg::bank_data_t host_bit_sel,
    input  logic                    config_en,
    input  logic                    config_wr,
    input  logic                    config_rd,
    input  glb_cfg_pkg::cfg_addr_t  config_addr,
    input  glb_bank_pkg::bank_data_t cfg_word,
    input  glb_bank_pkg::bank_data_t cfg_bit_sel,
    output logic                    ren,
    output logic                    wen,
    output glb_bank_pkg::bank_addr_t addr,
    output glb_bank_pkg::bank_data_t data_in,
    output glb_bank_pkg::bank_data_t data_in_bit_sel,
    output logic                    host_stall,
    output logic                    host_rd_valid,
    output logic                    config_rd_valid,
    output logic                    cfg_rd_issue
);

    import glb_bank_pkg::*;

    logic cfg_active;
    logic cfg_wr_act;
    logic cfg_rd_act;

    // write wins if both config strobes are up
    assign cfg_wr_act = config_en & config_wr;
    assign cfg_rd_act = config_en & config_rd & ~config_wr;
    assign cfg_active = cfg_wr_act | cfg_rd_act;

    // host strobe is dropped while config owns the sram
    assign host_stall = cfg_active;
    assign cfg_rd_issue = cfg_rd_act;

    always_comb begin
        if (cfg_active) begin
            ren = cfg_rd_act;
            wen = cfg_wr_act;
            addr = bank_addr_t'(config_addr);
            data_in = cfg_word;
            // reads never touch memory bits
            data_in_bit_sel = cfg_wr_act ? cfg_bit_sel : '0;
        end else begin
            ren = host_ren;
            wen = host_wen;
            addr = host_addr;
            data_in = host_data;
            data_in_bit_sel = host_bit_sel;
        end
    end

    // remember who issued the read, valid comes one cycle later
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            host_rd_valid <= 1'b0;
            config_rd_valid <= 1'b0;
        end else begin
            host_rd_valid <= host_ren & ~cfg_active;
            config_rd_valid <= cfg_rd_act;
        end
    end

    // host side must not mix strobes
    assert property (@(posedge clk) disable iff (reset) !(host_ren && host_wen));

    // one read per cycle at the sram, so only one valid follows
    assert property (@(posedge clk) disable iff (reset) !(host_rd_valid && config_rd_valid));

endmodule

`default_nettype wire

//--- verilog/glb_sram_controller.sv
// sram controller
// turns read and write strobes into macro pins
// keeps the last read word on data_out until the next read

`timescale 1ns/1ps

`include "glb_defines.svh"

`default_nettype none

module glb_sram_controller (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    ren,
    input  logic                    wen,
    input  glb_bank_pkg::bank_addr_t addr,
    input  glb_bank_pkg::bank_data_t data_in,
    input  glb_bank_pkg::bank_data_t data_in_bit_sel,
    output glb_bank_pkg::bank_data_t data_out,
    output glb_bank_pkg::bank_data_t sram_to_mem_data,
    output glb_bank_pkg::bank_data_t sram_to_mem_bit_sel,
    output logic                    sram_to_mem_cen,
    output logic                    sram_to_mem_wen,
    output glb_bank_pkg::mem_addr_t  sram_to_mem_addr,
    input  glb_bank_pkg::bank_data_t mem_to_sram_data
);

    import glb_bank_pkg::*;

    logic       ren_delay;
    bank_data_t data_out_reg;

    // macro pins straight from the strobes
    assign sram_to_mem_cen = ren | wen;
    assign sram_to_mem_wen = wen;
    // drop byte offset to get the word address
    assign sram_to_mem_addr = addr[`GLB_BANK_ADDR_BYTE_OFFSET +: $bits(mem_addr_t)];
    assign sram_to_mem_data = data_in;
    assign sram_to_mem_bit_sel = data_in_bit_sel;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ren_delay <= 1'b0;
            data_out_reg <= '0;
        end else begin
            ren_delay <= ren;
            data_out_reg <= data_out;
        end
    end

    // fresh macro word right after a read, else the held copy
    assign data_out = ren_delay ? mem_to_sram_data : data_out_reg;

    // single port macro, one access per cycle
    assert property (@(posedge clk) disable iff (reset) !(ren && wen));

endmodule

`default_nettype wire

//--- verilog/glb_cfg_adapter.sv
// configuration adapter
// packs half-word writes into masked word writes
// returns the addressed half of a read word

`timescale 1ns/1ps

`include "glb_defines.svh"

`default_nettype none

module glb_cfg_adapter (
    input  logic                    clk,
    input  logic                    reset,
    input  glb_cfg_pkg::cfg_addr_t  config_addr,
    input  glb_cfg_pkg::cfg_data_t  config_wr_data,
    input  logic                    cfg_rd_issue,
    input  glb_bank_pkg::bank_data_t data_out,
    output glb_bank_pkg::bank_data_t cfg_word,
    output glb_bank_pkg::bank_data_t cfg_bit_sel,
    output glb_cfg_pkg::cfg_data_t  config_rd_data
);

    import glb_bank_pkg::*;
    import glb_cfg_pkg::*;

    localparam int HALF_BIT = `GLB_BANK_ADDR_BYTE_OFFSET - 1;
    localparam int CW = `GLB_CONFIG_DATA_WIDTH;

    logic wr_upper;
    logic rd_upper;

    // half select from the byte address
    assign wr_upper = config_addr[HALF_BIT];

    always_comb begin
        if (wr_upper) begin
            cfg_word = {config_wr_data, {CW{1'b0}}};
            cfg_bit_sel = {{CW{1'b1}}, {CW{1'b0}}};
        end else begin
            cfg_word = {{CW{1'b0}}, config_wr_data};
            cfg_bit_sel = {{CW{1'b0}}, {CW{1'b1}}};
        end
    end

    // data shows up a cycle after issue, so keep the half bit
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_upper <= 1'b0;
        end else if (cfg_rd_issue) begin
            rd_upper <= wr_upper;
        end
    end

    assign config_rd_data = rd_upper ? data_out[CW +: CW] : data_out[0 +: CW];

    // two halves make exactly one word
    assert property (@(posedge clk) disable iff (reset)
        $bits(cfg_data_t) * 2 == $bits(bank_data_t));

endmodule

`default_nettype wire

//--- verilog/glb_sram_macro.sv
// behavioral sram macro
// single port, 512 words, bit-masked writes
// read data registered one edge after the enabled read

`timescale 1ns/1ps

`include "glb_defines.svh"

`default_nettype none

module glb_sram_macro (
    input  logic                    clk,
    input  logic                    cen,
    input  logic                    wen,
    input  glb_bank_pkg::mem_addr_t  addr,
    input  glb_bank_pkg::bank_data_t data,
    input  glb_bank_pkg::bank_data_t bit_sel,
    output glb_bank_pkg::bank_data_t q
);

    import glb_bank_pkg::*;

    // one word per address value
    localparam int DEPTH = 1 << (`GLB_BANK_ADDR_WIDTH - `GLB_BANK_ADDR_BYTE_OFFSET);

    bank_data_t mem [DEPTH];
    bank_data_t cur_word;

    assign cur_word = mem[addr];

    // contents undefined until written
    always_ff @(posedge clk) begin
        if (cen) begin
            if (wen) begin
                // only masked bits change
                mem[addr] <= (cur_word & ~bit_sel) | (data & bit_sel);
            end else begin
                q <= cur_word;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/glb_bank.sv
// global buffer bank
// host and configuration ports sharing one sram
// through the bank control, adapter and sram controller

`timescale 1ns/1ps

`include "glb_defines.svh"

`default_nettype none

module glb_bank (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    host_ren,
    input  logic                    host_wen,
    input  glb_bank_pkg::bank_addr_t host_addr,
    input  glb_bank_pkg::bank_data_t host_data,
    input  glb_bank_pkg::bank_data_t host_bit_sel,
    output logic                    host_stall,
    output logic                    host_rd_valid,
    output glb_bank_pkg::bank_data_t host_rd_data,
    input  logic                    config_en,
    input  logic                    config_wr,
    input  logic                    config_rd,
    input  glb_cfg_pkg::cfg_addr_t  config_addr,
    input  glb_cfg_pkg::cfg_data_t  config_wr_data,
    output logic                    config_rd_valid,
    output glb_cfg_pkg::cfg_data_t  config_rd_data
);

    import glb_bank_pkg::*;

    // arbitrated request into the controller
    logic       ren;
    logic       wen;
    bank_addr_t addr;
    bank_data_t data_in;
    bank_data_t data_in_bit_sel;

    // config packing and read bookkeeping
    bank_data_t cfg_word;
    bank_data_t cfg_bit_sel;
    logic       cfg_rd_issue;

    // macro pins
    bank_data_t sram_to_mem_data;
    bank_data_t sram_to_mem_bit_sel;
    logic       sram_to_mem_cen;
    logic       sram_to_mem_wen;
    mem_addr_t  sram_to_mem_addr;
    bank_data_t mem_to_sram_data;

    glb_bank_ctrl u_ctrl (
        .clk             (clk),
        .reset           (reset),
        .host_ren        (host_ren),
        .host_wen        (host_wen),
        .host_addr       (host_addr),
        .host_data       (host_data),
        .host_bit_sel    (host_bit_sel),
        .config_en       (config_en),
        .config_wr       (config_wr),
        .config_rd       (config_rd),
        .config_addr     (config_addr),
        .cfg_word        (cfg_word),
        .cfg_bit_sel     (cfg_bit_sel),
        .ren             (ren),
        .wen             (wen),
        .addr            (addr),
        .data_in         (data_in),
        .data_in_bit_sel (data_in_bit_sel),
        .host_stall      (host_stall),
        .host_rd_valid   (host_rd_valid),
        .config_rd_valid (config_rd_valid),
        .cfg_rd_issue    (cfg_rd_issue)
    );

    // held read word feeds both host data and config alignment
    glb_sram_controller u_sram_ctrl (
        .clk                 (clk),
        .reset               (reset),
        .ren                 (ren),
        .wen                 (wen),
        .addr                (addr),
        .data_in             (data_in),
        .data_in_bit_sel     (data_in_bit_sel),
        .data_out            (host_rd_data),
        .sram_to_mem_data    (sram_to_mem_data),
        .sram_to_mem_bit_sel (sram_to_mem_bit_sel),
        .sram_to_mem_cen     (sram_to_mem_cen),
        .sram_to_mem_wen     (sram_to_mem_wen),
        .sram_to_mem_addr    (sram_to_mem_addr),
        .mem_to_sram_data    (mem_to_sram_data)
    );

    glb_cfg_adapter u_cfg_adapter (
        .clk            (clk),
        .reset          (reset),
        .config_addr    (config_addr),
        .config_wr_data (config_wr_data),
        .cfg_rd_issue   (cfg_rd_issue),
        .data_out       (host_rd_data),
        .cfg_word       (cfg_word),
        .cfg_bit_sel    (cfg_bit_sel),
        .config_rd_data (config_rd_data)
    );

    glb_sram_macro u_sram (
        .clk     (clk),
        .cen     (sram_to_mem_cen),
        .wen     (sram_to_mem_wen),
        .addr    (sram_to_mem_addr),
        .data    (sram_to_mem_data),
        .bit_sel (sram_to_mem_bit_sel),
        .q       (mem_to_sram_data)
    );

endmodule

`default_nettype wire

//--- verification/glb_bank_tb.sv
// global buffer bank testbench
// directed tests for host and configuration access to one bank
// checks against a shadow memory kept in the testbench

`timescale 1ns/1ps

`include "glb_defines.svh"

`default_nettype none

module glb_bank_tb;

    import glb_bank_pkg::*;
    import glb_cfg_pkg::*;

    localparam int PERIOD = 8;
    localparam int DEPTH = 1 << (`GLB_BANK_ADDR_WIDTH - `GLB_BANK_ADDR_BYTE_OFFSET);
    localparam int N_FULL = 16;
    localparam int N_MASK = 8;
    localparam int N_CFG = 4;
    // reset, full, masked, config halves, contention, hold
    localparam int TEST_CYCLES = 12 + N_FULL * 3 + N_MASK * 4 + N_CFG * 11 + 8 + 12;
    localparam int MARGIN = 100;

    logic       clk;
    logic       reset;
    logic       host_ren;
    logic       host_wen;
    bank_addr_t host_addr;
    bank_data_t host_data;
    bank_data_t host_bit_sel;
    logic       host_stall;
    logic       host_rd_valid;
    bank_data_t host_rd_data;
    logic       config_en;
    logic       config_wr;
    logic       config_rd;
    cfg_addr_t  config_addr;
    cfg_data_t  config_wr_data;
    logic       config_rd_valid;
    cfg_data_t  config_rd_data;

    int          checks;
    int          mismatches;
    logic [31:0] lfsr;
    bank_data_t  shadow [DEPTH];

    glb_bank UUT (
        .clk             (clk),
        .reset           (reset),
        .host_ren        (host_ren),
        .host_wen        (host_wen),
        .host_addr       (host_addr),
        .host_data       (host_data),
        .host_bit_sel    (host_bit_sel),
        .host_stall      (host_stall),
        .host_rd_valid   (host_rd_valid),
        .host_rd_data    (host_rd_data),
        .config_en       (config_en),
        .config_wr       (config_wr),
        .config_rd       (config_rd),
        .config_addr     (config_addr),
        .config_wr_data  (config_wr_data),
        .config_rd_valid (config_rd_valid),
        .config_rd_data  (config_rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic bank_data_t rand_bits(input int n);
        bank_data_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[$bits(bank_data_t)-2:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    // word index is the byte address without its offset
    function automatic int word_of(input bank_addr_t a);
        return int'(a >> `GLB_BANK_ADDR_BYTE_OFFSET);
    endfunction

    function automatic cfg_data_t half_of(input bank_data_t w, input logic upper);
        return upper ? w[`GLB_CONFIG_DATA_WIDTH +: `GLB_CONFIG_DATA_WIDTH]
                     : w[0 +: `GLB_CONFIG_DATA_WIDTH];
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input bank_data_t got, input bank_data_t exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_half(input string name, input cfg_data_t got, input cfg_data_t exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // all bus tasks enter and leave 1 ns after a rising edge
    task automatic host_write(input bank_addr_t a, input bank_data_t d, input bank_data_t m);
        int w;
        w = word_of(a);
        host_wen = 1'b1;
        host_addr = a;
        host_data = d;
        host_bit_sel = m;
        #3;
        check_bit("host_stall", host_stall, 1'b0);
        @(posedge clk);
        #1;
        host_wen = 1'b0;
        // new bit where the mask is set, old bit elsewhere
        for (int b = 0; b < $bits(bank_data_t); b++) begin
            if (m[b]) begin
                shadow[w][b] = d[b];
            end
        end
    endtask

    // valid low in the request cycle, high exactly one cycle later
    task automatic host_read(input bank_addr_t a);
        host_ren = 1'b1;
        host_addr = a;
        #3;
        check_bit("host_rd_valid", host_rd_valid, 1'b0);
        @(posedge clk);
        #1;
        host_ren = 1'b0;
        #3;
        check_bit("host_rd_valid", host_rd_valid, 1'b1);
        check_word("host_rd_data", host_rd_data, shadow[word_of(a)]);
        @(posedge clk);
        #1;
    endtask

    task automatic cfg_write(input cfg_addr_t a, input cfg_data_t d);
        int w;
        w = word_of(a);
        config_en = 1'b1;
        config_wr = 1'b1;
        config_addr = a;
        config_wr_data = d;
        #3;
        check_bit("host_stall", host_stall, 1'b1);
        @(posedge clk);
        #1;
        config_en = 1'b0;
        config_wr = 1'b0;
        if (a[2]) begin
            shadow[w][`GLB_CONFIG_DATA_WIDTH +: `GLB_CONFIG_DATA_WIDTH] = d;
        end else begin
            shadow[w][0 +: `GLB_CONFIG_DATA_WIDTH] = d;
        end
    endtask

    task automatic cfg_read(input cfg_addr_t a);
        config_en = 1'b1;
        config_rd = 1'b1;
        config_addr = a;
        #3;
        check_bit("host_stall", host_stall, 1'b1);
        check_bit("config_rd_valid", config_rd_valid, 1'b0);
        @(posedge clk);
        #1;
        config_en = 1'b0;
        config_rd = 1'b0;
        #3;
        check_bit("config_rd_valid", config_rd_valid, 1'b1);
        check_bit("host_rd_valid", host_rd_valid, 1'b0);
        check_half("config_rd_data", config_rd_data, half_of(shadow[word_of(a)], a[2]));
        // config read also refreshes the held word
        check_word("host_rd_data", host_rd_data, shadow[word_of(a)]);
        @(posedge clk);
        #1;
    endtask

    task automatic test_reset();
        repeat (10) begin
            @(negedge clk);
            check_bit("host_rd_valid", host_rd_valid, 1'b0);
            check_bit("config_rd_valid", config_rd_valid, 1'b0);
            check_bit("host_stall", host_stall, 1'b0);
            check_word("host_rd_data", host_rd_data, '0);
        end
        @(posedge clk);
        #1;
        reset = 1'b0;
        #3;
        check_bit("host_rd_valid", host_rd_valid, 1'b0);
        check_bit("config_rd_valid", config_rd_valid, 1'b0);
        check_bit("host_stall", host_stall, 1'b0);
        check_word("host_rd_data", host_rd_data, '0);
        @(posedge clk);
        #1;
    endtask

    task automatic test_full_write_read();
        bank_addr_t addrs [N_FULL];
        for (int i = 0; i < N_FULL; i++) begin
            addrs[i] = bank_addr_t'(rand_bits($bits(bank_addr_t)));
            host_write(addrs[i], rand_bits($bits(bank_data_t)), '1);
        end
        // repeated addresses are fine, shadow keeps the last write
        for (int i = 0; i < N_FULL; i++) begin
            host_read(addrs[i]);
        end
    endtask

    task automatic test_masked_write();
        bank_addr_t a;
        for (int i = 0; i < N_MASK; i++) begin
            a = bank_addr_t'(rand_bits($bits(bank_addr_t)));
            host_write(a, rand_bits($bits(bank_data_t)), '1);
            host_write(a, rand_bits($bits(bank_data_t)), rand_bits($bits(bank_data_t)));
            host_read(a);
        end
    endtask

    task automatic test_cfg_halves();
        bank_addr_t base;
        for (int i = 0; i < N_CFG; i++) begin
            base = bank_addr_t'(rand_bits(9) << `GLB_BANK_ADDR_BYTE_OFFSET);
            host_write(base, rand_bits($bits(bank_data_t)), '1);
            // upper first, lower half still from the host
            cfg_write(base | 12'h004, cfg_data_t'(rand_bits($bits(cfg_data_t))));
            host_read(base);
            cfg_write(base, cfg_data_t'(rand_bits($bits(cfg_data_t))));
            host_read(base);
            cfg_read(base);
            cfg_read(base | 12'h004);
        end
    endtask

    task automatic test_contention();
        bank_addr_t base;
        bank_data_t host_word;
        cfg_data_t  cfg_half;
        base = bank_addr_t'(rand_bits(9) << `GLB_BANK_ADDR_BYTE_OFFSET);
        host_word = rand_bits($bits(bank_data_t));
        cfg_half = cfg_data_t'(rand_bits($bits(cfg_data_t)));
        host_write(base, rand_bits($bits(bank_data_t)), '1);
        host_wen = 1'b1;
        host_addr = base;
        host_data = host_word;
        host_bit_sel = '1;
        config_en = 1'b1;
        config_wr = 1'b1;
        config_addr = base;
        config_wr_data = cfg_half;
        #3;
        check_bit("host_stall", host_stall, 1'b1);
        @(posedge clk);
        #1;
        host_wen = 1'b0;
        config_en = 1'b0;
        config_wr = 1'b0;
        // only the config half lands, host write dropped
        shadow[word_of(base)][0 +: `GLB_CONFIG_DATA_WIDTH] = cfg_half;
        host_read(base);
        host_write(base, host_word, '1);
        host_read(base);
    endtask

    task automatic test_hold();
        bank_addr_t a;
        bank_data_t held;
        a = bank_addr_t'(rand_bits($bits(bank_addr_t)));
        host_write(a, rand_bits($bits(bank_data_t)), '1);
        host_read(a);
        held = shadow[word_of(a)];
        repeat (3) begin
            #3;
            check_word("host_rd_data", host_rd_data, held);
            @(posedge clk);
            #1;
        end
        host_write(a, ~held, '1);
        #3;
        check_word("host_rd_data", host_rd_data, held);
        @(posedge clk);
        #1;
        host_read(a);
    endtask

    // watchdog
    initial begin
        #((TEST_CYCLES + MARGIN) * PERIOD);
        $display("Timeout: tests did not finish within %0d cycles", TEST_CYCLES + MARGIN);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        reset = 1'b1;
        host_ren = 1'b0;
        host_wen = 1'b0;
        host_addr = '0;
        host_data = '0;
        host_bit_sel = '0;
        config_en = 1'b0;
        config_wr = 1'b0;
        config_rd = 1'b0;
        config_addr = '0;
        config_wr_data = '0;
        checks = 0;
        mismatches = 0;
        lfsr = 32'h2611_2a69;

        test_reset();
        test_full_write_read();
        test_masked_write();
        test_cfg_halves();
        test_contention();
        test_hold();

        $display("checks run: %0d, mismatches: %0d", checks, mismatches);
        if (mismatches == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+verilog
verilog/glb_bank_pkg.sv
verilog/glb_cfg_pkg.sv
verilog/glb_bank_ctrl.sv
verilog/glb_sram_controller.sv
verilog/glb_cfg_adapter.sv
verilog/glb_sram_macro.sv
verilog/glb_bank.sv
verification/glb_bank_tb.sv

//--- Bender.yml
package:
  name: glb_bank

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/glb_bank_pkg.sv
      - verilog/glb_cfg_pkg.sv
      - verilog/glb_bank_ctrl.sv
      - verilog/glb_sram_controller.sv
      - verilog/glb_cfg_adapter.sv
      - verilog/glb_sram_macro.sv
      - verilog/glb_bank.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/glb_bank_tb.sv
